/* files.f */
+incdir+design
design/fetch_pkg.sv
design/backend_pkg.sv
design/pc_reg.sv
design/bpu.sv
design/inst_buffer.sv
design/frontend_top.sv
test/frontend_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --timescale 1ns/10ps \
    --top-module frontend_tb \
    -f files.f \
    -o frontend_sim

./obj_dir/frontend_sim

/* test/frontend_tb.sv */
`timescale 1ns/10ps
`include "frontend_config.svh"

module frontend_tb;

    localparam logic [31:0] BEQ_PC     = `FE_RESET_PC + 32'h20;
    localparam logic [31:0] B_PC       = `FE_RESET_PC + 32'h48;
    localparam logic [31:0] BEQ_TARGET = `FE_RESET_PC + 32'h40;
    localparam logic [31:0] B_TARGET   = `FE_RESET_PC + 32'h10;
    localparam int FULL_LEVEL     = `FE_BUF_DEPTH - 3;
    localparam int TIMEOUT_CYCLES = 4000;  // About four times the test length

    logic                         clk           = 1'b0;
    logic                         rst_n         = 1'b0;
    logic                         icache_stall  = 1'b0;
    logic                         pause_decoder = 1'b0;
    fetch_pkg::fetch_resp_t       fetch_resp    = '0;
    backend_pkg::redirect_t       redirect      = '0;
    backend_pkg::bpu_update_t     bpu_update    = '0;
    fetch_pkg::fetch_req_t        fetch_req;
    backend_pkg::inst_pkt_t [1:0] out_pkt;
    logic [1:0]                   send_inst_en;
    logic                         buffer_full;
    logic                         bpu_flush;
    logic                         req_take;

    int          occ;                      // Entries the buffer should hold
    logic [31:0] exp_pc;
    logic        exp_halted;
    logic [1:0]        sh_btb;             // Index 0 is the BEQ, 1 the B
    logic [1:0]        sh_cond;
    logic [1:0][1:0]   sh_cnt;
    logic [1:0][31:0]  sh_target;
    int pkt_count     = 0;
    int beq_taken_cnt = 0;
    int beq_fall_cnt  = 0;
    int b_taken_cnt   = 0;
    int exc_cnt       = 0;
    int cycle_cnt     = 0;

    frontend_top uut (
        .clk,
        .rst_n,
        .icache_stall,
        .fetch_resp,
        .redirect,
        .bpu_update,
        .pause_decoder,
        .fetch_req,
        .out_pkt,
        .send_inst_en,
        .buffer_full,
        .bpu_flush
    );

    always #5 clk = ~clk;

    task automatic stop_with_failure();
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error %s got %h exp %h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic require_seen(input logic ok, input string what);
        if (!ok) begin
            $display("%s", what);
            stop_with_failure();
        end
    endtask

    function automatic logic [31:0] mem_inst(input logic [31:0] pc);
        if (pc == BEQ_PC) begin
            return {6'h16, 26'h000_0408};
        end else if (pc == B_PC) begin
            return {6'h14, 26'h000_0000};
        end
        return {6'h00, pc[27:2]};  // ADD-like word tagged by its address
    endfunction

    function automatic logic shadow_sel(input logic [31:0] pc);
        return (pc == B_PC);
    endfunction

    function automatic logic predict_taken(input logic [31:0] pc);
        logic sel;
        logic hit;
        sel = shadow_sel(pc);
        hit = ((pc == BEQ_PC) || (pc == B_PC)) && sh_btb[sel]
              && (!sh_cond[sel] || sh_cnt[sel][1]);
        return hit;
    endfunction

    function automatic logic [31:0] expected_next_pc(input logic [31:0] pc, input logic trained);
        return trained ? sh_target[shadow_sel(pc)] : pc + 32'd4;
    endfunction

    // Next fetch group after the one at pc
    function automatic logic [31:0] group_after(input logic [31:0] pc);
        if (pc[2]) begin
            return pc + 32'd4;
        end
        return (pc & ~32'h7) + 32'd8;
    endfunction

    function automatic logic [1:0] expected_send(input int n, input logic paused);
        if (paused || (n == 0)) begin
            return 2'b00;
        end else if (n == 1) begin
            return 2'b01;
        end
        return 2'b11;
    endfunction

    task automatic check_packet(input backend_pkg::inst_pkt_t pkt);
        logic taken;
        if (exp_halted) begin
            $display("Packet at pc %h was sent after a fetch exception", pkt.pc);
            stop_with_failure();
        end else begin
            check_val("pc", pkt.pc, exp_pc);
            if (exp_pc[1:0] != 2'b00) begin
                check_val("is_exception", 32'(pkt.is_exception), 32'd1);
                check_val("exception_cause", 32'(pkt.exception_cause),
                          32'(fetch_pkg::EXC_ADEF));
                check_val("pred_taken", 32'(pkt.pred_taken), 32'd0);
                exc_cnt    <= exc_cnt + 1;
                exp_halted  = 1'b1;
            end else begin
                taken = predict_taken(pkt.pc);
                check_val("is_exception", 32'(pkt.is_exception), 32'd0);
                check_val("inst", pkt.inst, mem_inst(pkt.pc));
                check_val("pred_taken", 32'(pkt.pred_taken), 32'(taken));
                if (taken) begin
                    check_val("pred_target", pkt.pred_target, sh_target[shadow_sel(pkt.pc)]);
                end
                if (pkt.pc == BEQ_PC && taken) beq_taken_cnt <= beq_taken_cnt + 1;
                if (pkt.pc == BEQ_PC && !taken) beq_fall_cnt <= beq_fall_cnt + 1;
                if (pkt.pc == B_PC && taken) b_taken_cnt <= b_taken_cnt + 1;
                exp_pc = expected_next_pc(pkt.pc, taken);
            end
        end
    endtask

    // Cache model answers an accepted request at the next edge
    assign req_take = (fetch_req.inst_en != 2'b00) && !icache_stall
                      && !redirect.flush && !bpu_flush;

    always @(posedge clk) begin
        if (!rst_n) begin
            fetch_resp   <= '0;
            icache_stall <= 1'b0;
        end else if (req_take) begin
            fetch_resp.valid           <= fetch_req.inst_en;
            fetch_resp.pc              <= fetch_req.pc;
            fetch_resp.inst[0]         <= fetch_req.is_exception ? 32'd0 : mem_inst(fetch_req.pc);
            fetch_resp.inst[1]         <= fetch_req.inst_en[1] ? mem_inst(fetch_req.pc + 32'd4)
                                                               : 32'd0;
            fetch_resp.is_exception    <= fetch_req.is_exception;
            fetch_resp.exception_cause <= fetch_req.exception_cause;
            icache_stall               <= 1'b0;  // No stall in the response cycle
        end else begin
            fetch_resp.valid <= 2'b00;
            icache_stall     <= ($urandom % 32'd100) < 32'd20;
        end
    end

    always @(posedge clk) begin
        int sent;
        int written;
        logic sel;
        logic exp_bflush;
        logic [31:0] slot1_pc;
        if (!rst_n) begin
            occ        = 0;
            exp_pc     = `FE_RESET_PC;
            exp_halted = 1'b0;
            sh_btb     = 2'b00;
            sh_cond    = 2'b00;
            sh_cnt     = {2'b01, 2'b01};  // Weakly not taken
            sh_target  = '0;
            check_val("bpu_flush", 32'(bpu_flush), 32'd0);
        end else begin
            sent = 0;
            check_val("buffer_full", 32'(buffer_full), 32'(occ >= FULL_LEVEL));
            check_val("send_inst_en", 32'(send_inst_en), 32'(expected_send(occ, pause_decoder)));
            exp_bflush = 1'b0;
            slot1_pc   = fetch_resp.pc + 32'd4;
            if (!redirect.flush && !fetch_resp.is_exception && fetch_resp.valid[0]) begin
                if (predict_taken(fetch_resp.pc)) begin
                    exp_bflush = sh_target[shadow_sel(fetch_resp.pc)]
                                 != group_after(fetch_resp.pc);
                end else if (fetch_resp.valid[1] && predict_taken(slot1_pc)) begin
                    exp_bflush = sh_target[shadow_sel(slot1_pc)]
                                 != group_after(fetch_resp.pc);
                end
            end
            check_val("bpu_flush", 32'(bpu_flush), 32'(exp_bflush));
            if (send_inst_en[0]) begin
                check_packet(out_pkt[0]);
                sent = sent + 1;
            end
            if (send_inst_en[1]) begin
                check_packet(out_pkt[1]);
                sent = sent + 1;
            end
            pkt_count <= pkt_count + sent;
            written = 0;
            if (fetch_resp.valid[0]) begin
                written = 1;
                if (fetch_resp.valid[1]
                    && (fetch_resp.is_exception || !predict_taken(fetch_resp.pc))) begin
                    written = 2;  // Slot 1 survives
                end
            end
            if (redirect.flush) begin
                occ        = 0;
                exp_pc     = redirect.new_pc;
                exp_halted = 1'b0;
            end else begin
                occ = occ + written - sent;
            end
            if (bpu_update.valid) begin
                sel = shadow_sel(bpu_update.pc);
                if (bpu_update.taken) begin
                    sh_btb[sel]    = 1'b1;
                    sh_target[sel] = bpu_update.target;
                    sh_cond[sel]   = bpu_update.is_cond;
                    if (sh_cnt[sel] != 2'b11) sh_cnt[sel] = sh_cnt[sel] + 2'd1;
                end else if (sh_cnt[sel] != 2'b00) begin
                    sh_cnt[sel] = sh_cnt[sel] - 2'd1;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycle_cnt);
            stop_with_failure();
        end
    end

    task automatic wait_packets(input int n);
        int target;
        target = pkt_count + n;
        while (pkt_count < target) @(posedge clk);
    endtask

    task automatic redirect_to(input logic [31:0] pc);
        redirect.flush  <= 1'b1;
        redirect.new_pc <= pc;
        @(posedge clk);
        redirect.flush  <= 1'b0;
    endtask

    task automatic train_branch(input logic [31:0] pc, input logic taken,
                                input logic [31:0] target, input logic cond);
        bpu_update.valid   <= 1'b1;
        bpu_update.pc      <= pc;
        bpu_update.taken   <= taken;
        bpu_update.target  <= target;
        bpu_update.is_cond <= cond;
        @(posedge clk);
        bpu_update.valid   <= 1'b0;
    endtask

    initial begin
        logic [31:0] far_pc;
        int mark;
        void'($urandom(32'h7133_b259));
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        wait_packets(40);
        require_seen(beq_fall_cnt != 0, "Untrained BEQ never reached the decoder");
        far_pc = 32'h2000_0000 | ($urandom & 32'h0000_fffc);  // Far from both branches
        redirect_to(far_pc);
        wait_packets(20);
        train_branch(BEQ_PC, 1'b1, BEQ_TARGET, 1'b1);
        train_branch(BEQ_PC, 1'b1, BEQ_TARGET, 1'b1);
        train_branch(B_PC, 1'b1, B_TARGET, 1'b0);
        redirect_to(`FE_RESET_PC);
        wait_packets(60);
        require_seen(beq_taken_cnt != 0, "Trained BEQ was never predicted taken");
        require_seen(b_taken_cnt != 0, "Trained B was never predicted taken");
        far_pc = 32'h2000_0000 | ($urandom & 32'h0000_fffc);
        redirect_to(far_pc);
        wait_packets(10);
        train_branch(BEQ_PC, 1'b0, BEQ_TARGET, 1'b1);
        train_branch(BEQ_PC, 1'b0, BEQ_TARGET, 1'b1);
        mark = beq_fall_cnt;
        redirect_to(`FE_RESET_PC);
        wait_packets(60);
        require_seen(beq_fall_cnt != mark, "BEQ trained down was never followed by pc+4");
        repeat (300) begin
            pause_decoder <= ($urandom % 32'd100) < 32'd40;
            @(posedge clk);
        end
        pause_decoder <= 1'b0;
        wait_packets(10);
        far_pc = 32'h2000_0000 | ($urandom & 32'h0000_fffc);
        redirect_to(far_pc | 32'h2);
        wait_packets(1);
        repeat (30) @(posedge clk);
        require_seen(exc_cnt == 1, "Misaligned redirect did not give one exception packet");
        redirect_to(`FE_RESET_PC);
        wait_packets(4);
        if (pkt_count < 200) begin
            $display("Only %0d packets were checked", pkt_count);
            stop_with_failure();
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

/* design/frontend_top.sv */
`timescale 1ns/10ps

module frontend_top (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         icache_stall,
    input  fetch_pkg::fetch_resp_t       fetch_resp,
    input  backend_pkg::redirect_t       redirect,
    input  backend_pkg::bpu_update_t     bpu_update,
    input  logic                         pause_decoder,
    output fetch_pkg::fetch_req_t        fetch_req,
    output backend_pkg::inst_pkt_t [1:0] out_pkt,
    output logic [1:0]                   send_inst_en,
    output logic                         buffer_full,
    output logic                         bpu_flush
);

    logic        pred_taken;
    logic [31:0] pred_target;
    logic        pred_slot;

    pc_reg u_pc_reg (
        .clk,
        .rst_n,
        .icache_stall,
        .buffer_full,
        .redirect,
        .pred_taken  (bpu_flush),  // Only a non-sequential target moves the PC
        .pred_target,
        .fetch_req
    );

    bpu u_bpu (
        .clk,
        .rst_n,
        .fetch_resp,
        .flush       (redirect.flush),
        .bpu_update,
        .pred_taken,
        .pred_target,
        .pred_slot,
        .bpu_flush
    );

    inst_buffer u_inst_buffer (
        .clk,
        .rst_n,
        .flush       (redirect.flush),
        .pause_decoder,
        .fetch_resp,
        .pred_taken,
        .pred_target,
        .pred_slot,
        .out_pkt,
        .send_inst_en,
        .buffer_full
    );

endmodule

/* design/inst_buffer.sv */
`timescale 1ns/10ps
`include "frontend_config.svh"

module inst_buffer (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         flush,
    input  logic                         pause_decoder,
    input  fetch_pkg::fetch_resp_t       fetch_resp,
    input  logic                         pred_taken,
    input  logic [31:0]                  pred_target,
    input  logic                         pred_slot,
    output backend_pkg::inst_pkt_t [1:0] out_pkt,
    output logic [1:0]                   send_inst_en,
    output logic                         buffer_full
);

    localparam int DEPTH = `FE_BUF_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    backend_pkg::inst_pkt_t entries [DEPTH];

    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [PTR_W:0]   count;

    backend_pkg::inst_pkt_t [1:0] wr_pkt;

    logic [1:0]       wr_en;
    logic [1:0]       wr_num;
    logic [1:0]       rd_num;
    logic [PTR_W-1:0] wr_ptr1;
    logic [PTR_W-1:0] head_p1;

    // Build packets from the response
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            wr_pkt[s].pc              = fetch_resp.pc + ((s == 1) ? 32'd4 : 32'd0);
            wr_pkt[s].inst            = fetch_resp.inst[s];
            wr_pkt[s].is_exception    = fetch_resp.is_exception;
            wr_pkt[s].exception_cause = fetch_resp.exception_cause;
            wr_pkt[s].pred_taken      = pred_taken && (pred_slot == (s == 1));
            wr_pkt[s].pred_target     = wr_pkt[s].pred_taken ? pred_target : 32'd0;
        end
    end

    assign wr_en[0] = fetch_resp.valid[0] && !flush;
    assign wr_en[1] = fetch_resp.valid[1] && !flush && !(pred_taken && !pred_slot);
    assign wr_num   = {1'b0, wr_en[0]} + {1'b0, wr_en[1]};
    assign wr_ptr1  = tail + PTR_W'(wr_en[0]);  // Slot 1 packs behind slot 0

    assign send_inst_en[0] = !pause_decoder && (count != '0);
    assign send_inst_en[1] = !pause_decoder && (count[PTR_W:1] != '0);
    assign rd_num          = {1'b0, send_inst_en[0]} + {1'b0, send_inst_en[1]};

    assign head_p1    = head + PTR_W'(1);
    assign out_pkt[0] = entries[head];
    assign out_pkt[1] = entries[head_p1];

    // Keep room for one response in flight
    assign buffer_full = (count > (PTR_W+1)'(DEPTH - 4));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head + PTR_W'(rd_num);
            tail  <= tail + PTR_W'(wr_num);
            count <= count + (PTR_W+1)'(wr_num) - (PTR_W+1)'(rd_num);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en[0]) begin
            entries[tail] <= wr_pkt[0];
        end
        if (wr_en[1]) begin
            entries[wr_ptr1] <= wr_pkt[1];
        end
    end

endmodule

/* design/bpu.sv */
`timescale 1ns/10ps
`include "frontend_config.svh"

module bpu (
    input  logic                     clk,
    input  logic                     rst_n,
    input  fetch_pkg::fetch_resp_t   fetch_resp,
    input  logic                     flush,
    input  backend_pkg::bpu_update_t bpu_update,
    output logic                     pred_taken,
    output logic [31:0]              pred_target,
    output logic                     pred_slot,
    output logic                     bpu_flush
);

    localparam int BTB_IW = $clog2(`FE_BTB_ENTRIES);
    localparam int BHT_IW = $clog2(`FE_BHT_ENTRIES);
    localparam int TAG_W  = 30 - BTB_IW;

    logic [`FE_BTB_ENTRIES-1:0] btb_valid;
    logic [TAG_W-1:0]           btb_tag    [`FE_BTB_ENTRIES];
    logic [31:0]                btb_target [`FE_BTB_ENTRIES];
    logic                       btb_cond   [`FE_BTB_ENTRIES];
    logic [1:0]                 bht        [`FE_BHT_ENTRIES];

    logic [1:0][31:0] slot_pc;
    logic [1:0][31:0] slot_target;
    logic [1:0]       slot_taken;
    logic [31:0]      seq_pc;

    logic [BTB_IW-1:0] upd_btb_idx;
    logic [BHT_IW-1:0] upd_bht_idx;

    // Predecode and table lookup per slot
    always_comb begin
        logic [BTB_IW-1:0] bi;
        logic [BHT_IW-1:0] hi;
        logic              hit;
        for (int s = 0; s < 2; s++) begin
            slot_pc[s]     = fetch_resp.pc + ((s == 1) ? 32'd4 : 32'd0);
            bi             = slot_pc[s][BTB_IW+1:2];
            hi             = slot_pc[s][BHT_IW+1:2];
            hit            = btb_valid[bi] && (btb_tag[bi] == slot_pc[s][31:BTB_IW+2]);
            slot_target[s] = btb_target[bi];
            slot_taken[s]  = fetch_resp.valid[s] && hit
                             && fetch_pkg::is_branch(fetch_resp.inst[s][31:26])
                             && (!btb_cond[bi] || bht[hi][1]);
        end
    end

    // Address the PC register already moved on to
    assign seq_pc = fetch_resp.pc[2] ? fetch_resp.pc + 32'd4
                                     : {fetch_resp.pc[31:3] + 29'd1, 3'b000};

    assign pred_taken  = (|slot_taken) && !flush && !fetch_resp.is_exception;
    assign pred_slot   = !slot_taken[0];  // Lowest taken slot wins
    assign pred_target = slot_target[pred_slot];
    assign bpu_flush   = pred_taken && (pred_target != seq_pc);

    assign upd_btb_idx = bpu_update.pc[BTB_IW+1:2];
    assign upd_bht_idx = bpu_update.pc[BHT_IW+1:2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            btb_valid <= '0;
            for (int i = 0; i < `FE_BHT_ENTRIES; i++) begin
                bht[i] <= 2'b01;  // Weakly not taken
            end
        end else if (bpu_update.valid) begin
            if (bpu_update.taken) begin
                btb_valid[upd_btb_idx] <= 1'b1;
            end
            if (bpu_update.taken && (bht[upd_bht_idx] != 2'b11)) begin
                bht[upd_bht_idx] <= bht[upd_bht_idx] + 2'd1;
            end else if (!bpu_update.taken && (bht[upd_bht_idx] != 2'b00)) begin
                bht[upd_bht_idx] <= bht[upd_bht_idx] - 2'd1;
            end
        end
    end

    // BTB payload
    always_ff @(posedge clk) begin
        if (bpu_update.valid && bpu_update.taken) begin
            btb_tag[upd_btb_idx]    <= bpu_update.pc[31:BTB_IW+2];
            btb_target[upd_btb_idx] <= bpu_update.target;
            btb_cond[upd_btb_idx]   <= bpu_update.is_cond;
        end
    end

endmodule

/* design/pc_reg.sv */
`timescale 1ns/10ps
`include "frontend_config.svh"

module pc_reg (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   icache_stall,
    input  logic                   buffer_full,
    input  backend_pkg::redirect_t redirect,
    input  logic                   pred_taken,
    input  logic [31:0]            pred_target,
    output fetch_pkg::fetch_req_t  fetch_req
);

    typedef enum logic [1:0] {
        PC_IDLE,
        PC_RUN,
        PC_HALT
    } pc_state_e;

    pc_state_e   state;
    logic [31:0] pc;
    logic [31:0] seq_pc;
    logic        misaligned;
    logic        req_on;

    assign misaligned = (pc[1:0] != 2'b00);
    assign req_on     = (state == PC_RUN) && !buffer_full;
    assign seq_pc     = pc[2] ? pc + 32'd4 : {pc[31:3] + 29'd1, 3'b000};

    always_comb begin
        fetch_req.pc              = pc;
        fetch_req.is_exception    = misaligned;
        fetch_req.exception_cause = misaligned ? fetch_pkg::EXC_ADEF : fetch_pkg::EXC_NONE;
        fetch_req.inst_en         = 2'b00;
        if (req_on) begin
            // Group stops at the 8-byte boundary
            fetch_req.inst_en = (misaligned || pc[2]) ? 2'b01 : 2'b11;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= PC_IDLE;
            pc    <= `FE_RESET_PC;
        end else if (redirect.flush) begin
            state <= PC_RUN;
            pc    <= redirect.new_pc;
        end else if (pred_taken) begin
            pc <= pred_target;  // Predicted branch target
        end else if (state == PC_IDLE) begin
            state <= PC_RUN;
        end else if (req_on && !icache_stall) begin
            if (misaligned) begin
                state <= PC_HALT;  // Wait for the next flush
            end else begin
                pc <= seq_pc;
            end
        end
    end

endmodule

/* design/backend_pkg.sv */
package backend_pkg;

    typedef struct packed {
        logic        flush;
        logic [31:0] new_pc;
    } redirect_t;

    // Resolved branch from the back end
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        taken;
        logic [31:0] target;
        logic        is_cond;  // Set for BEQ and BNE
    } bpu_update_t;

    // One instruction slot toward the decoder
    typedef struct packed {
        logic [31:0]           pc;
        logic [31:0]           inst;
        logic                  is_exception;
        fetch_pkg::exc_cause_e exception_cause;
        logic                  pred_taken;
        logic [31:0]           pred_target;
    } inst_pkt_t;

endpackage

/* design/fetch_pkg.sv */
package fetch_pkg;

    // Major opcode in inst[31:26]
    typedef enum logic [5:0] {
        BR_B   = 6'h14,
        BR_BL  = 6'h15,
        BR_BEQ = 6'h16,
        BR_BNE = 6'h17
    } br_op_e;

    typedef enum logic [1:0] {
        EXC_NONE = 2'd0,
        EXC_ADEF = 2'd1  // Misaligned fetch address
    } exc_cause_e;

    // PC register to instruction cache
    typedef struct packed {
        logic [31:0] pc;
        logic [1:0]  inst_en;
        logic        is_exception;
        exc_cause_e  exception_cause;
    } fetch_req_t;

    // Instruction cache back to the front end
    typedef struct packed {
        logic [1:0]       valid;
        logic [31:0]      pc;    // Address of slot 0
        logic [1:0][31:0] inst;
        logic             is_exception;
        exc_cause_e       exception_cause;
    } fetch_resp_t;

    function automatic logic is_branch(logic [5:0] op);
        logic hit;
        hit = (op == BR_B) || (op == BR_BL) || (op == BR_BEQ) || (op == BR_BNE);
        return hit;
    endfunction

endpackage

/* design/frontend_config.svh */
`ifndef FRONTEND_CONFIG_SVH
`define FRONTEND_CONFIG_SVH

// First fetch address after reset
`define FE_RESET_PC 32'h1c00_0000

`define FE_BTB_ENTRIES 16
`define FE_BHT_ENTRIES 64

// Instruction buffer depth, power of two
`define FE_BUF_DEPTH 16

`endif
